/* seven_stage_core.f */
verilog/rv32_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch_unit.sv
verilog/register_file.sv
verilog/decode_unit.sv
verilog/execution_unit.sv
verilog/memory_writeback_unit.sv
verilog/seven_stage_core.sv
sim/seven_stage_core_assert.sv
sim/seven_stage_core_tb.sv

/* sim/seven_stage_core_assert.sv */
`timescale 1ns/100ps

module seven_stage_core_assert
  import rv32_isa_pkg::*;
(
  input logic  clock,
  input logic  reset,
  input logic  fetch_read,
  input word_t fetch_address_out,
  input logic  memory_read,
  input logic  memory_write
);

  int failures = 0;

  // one data access per cycle
  strobes_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(memory_read && memory_write))
  else
  begin
    failures++;
    $error("memory_read and memory_write high in the same cycle");
  end

  // first reset cycle still shows the previous run
  quiet_in_reset: assert property (@(posedge clock)
    (reset && $past(reset)) |-> !(fetch_read || memory_read || memory_write))
  else
  begin
    failures++;
    $error("strobe high while reset is held");
  end

  fetch_step: assert property (@(posedge clock) disable iff (reset)
    (fetch_read && $past(fetch_read)) |->
      (fetch_address_out == $past(fetch_address_out) + 32'd4))
  else
  begin
    failures++;
    $error("fetch address did not advance by one word");
  end

endmodule

bind seven_stage_core seven_stage_core_assert assert0 (
  .clock             (clock),
  .reset             (reset),
  .fetch_read        (fetch_read),
  .fetch_address_out (fetch_address_out),
  .memory_read       (memory_read),
  .memory_write      (memory_write)
);

/* sim/seven_stage_core_tb.sv */
`timescale 1ns/100ps

module seven_stage_core_tb
  import rv32_isa_pkg::*;
();

  typedef struct packed {
    word_t address;
    word_t data;
  } store_rec_t;

  logic  clock;
  logic  reset;
  logic  start;
  word_t program_address;
  word_t fetch_data_in = NOP_INSTR;
  word_t memory_data_in = '0;
  logic  fetch_read;
  word_t fetch_address_out;
  logic  memory_read;
  logic  memory_write;
  word_t memory_address_out;
  word_t memory_data_out;

  word_t      program_q [$];     // word 0 sits at program_address
  word_t      data_mem [word_t]; // sparse data memory
  store_rec_t store_q [$];       // stores seen on the bus
  store_rec_t expect_q [$];
  word_t      load_q [$];        // load addresses seen on the bus
  logic       fetch_pending = 1'b0;
  word_t      fetch_addr_q = '0;
  logic       read_pending = 1'b0;
  word_t      read_addr_q = '0;
  int         cycle_count = 0;
  int         checks = 0;
  int         value_errors = 0;
  int         other_errors = 0;
  int         seed = 32'hb17cb706;

  seven_stage_core dut0 (
    .clock              (clock),
    .reset              (reset),
    .start              (start),
    .program_address    (program_address),
    .fetch_data_in      (fetch_data_in),
    .memory_data_in     (memory_data_in),
    .fetch_read         (fetch_read),
    .fetch_address_out  (fetch_address_out),
    .memory_read        (memory_read),
    .memory_write       (memory_write),
    .memory_address_out (memory_address_out),
    .memory_data_out    (memory_data_out)
  );

  always #2 clock = ~clock;

  always @(posedge clock)
    cycle_count <= cycle_count + 1;

  function automatic word_t instr_at(word_t address);
    word_t offset;
    offset = (address - program_address) >> 2;
    if (address >= program_address && offset < program_q.size())
      return program_q[offset];
    return NOP_INSTR; // past the end of the program
  endfunction

  function automatic word_t read_word(word_t address);
    if (data_mem.exists(address))
      return data_mem[address];
    return (address * 32'h9e37_79b1) ^ 32'h5a5a_c3c3; // fill from the full address
  endfunction

  // instruction memory answers one cycle after fetch_read
  always @(negedge clock)
  begin
    fetch_data_in <= fetch_pending ? instr_at(fetch_addr_q) : NOP_INSTR;
    fetch_pending <= fetch_read;
    fetch_addr_q  <= fetch_address_out;
  end

  // data memory and bus monitor
  always @(negedge clock)
  begin
    memory_data_in <= read_pending ? read_word(read_addr_q) : '0;
    read_pending   <= memory_read && !reset;
    read_addr_q    <= memory_address_out;
    if (!reset && memory_read)
      load_q.push_back(memory_address_out);
    if (!reset && memory_write)
    begin
      data_mem[memory_address_out] = memory_data_out;
      store_q.push_back({memory_address_out, memory_data_out});
    end
  end

  function automatic word_t r_format(logic [6:0] funct7, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] funct3, reg_idx_t rd);
    return {funct7, rs2, rs1, funct3, rd, OP_REG};
  endfunction

  function automatic word_t i_format(logic [11:0] imm, reg_idx_t rs1, logic [2:0] funct3,
                                     reg_idx_t rd, logic [6:0] opcode);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic word_t s_format(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t u_format(logic [19:0] imm, reg_idx_t rd);
    return {imm, rd, OP_LUI};
  endfunction

  task automatic compare_word(input string test, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected)
    begin
      value_errors++;
      $display("Error: %s expected %h actual %h", test, expected, actual);
    end
  endtask

  task automatic compare_bit(input string test, input logic expected, input logic actual);
    checks++;
    if (actual !== expected)
    begin
      value_errors++;
      $display("Error: %s expected %b actual %b", test, expected, actual);
    end
  endtask

  // lui plus addi, upper part rounded for the sign of the low twelve bits
  task automatic load_constant(input reg_idx_t rd, input word_t value);
    word_t upper;
    upper = (value + 32'h800) >> 12;
    program_q.push_back(u_format(upper[19:0], rd));
    program_q.push_back(i_format(value[11:0], rd, F3_ADD_SUB, rd, OP_IMM));
  endtask

  task automatic store_and_expect(input reg_idx_t rs2, input word_t address, input word_t value);
    program_q.push_back(s_format(address[11:0], rs2, 5'd0));
    expect_q.push_back({address, value});
  endtask

  task automatic apply_reset();
    @(negedge clock);
    reset = 1'b1;
    repeat (10) @(negedge clock);
    reset = 1'b0;
  endtask

  task automatic start_program(input word_t base);
    program_address = base;
    apply_reset();
    store_q.delete();
    load_q.delete();
    start = 1'b1;
    @(negedge clock);
    start = 1'b0; // first fetch cycle from here
  endtask

  task automatic check_stores(input string test);
    int waited;
    waited = 0;
    while (store_q.size() < expect_q.size() && waited < 200)
    begin
      @(posedge clock);
      waited++;
    end
    if (store_q.size() < expect_q.size())
    begin
      other_errors++;
      $display("%s: only %0d of %0d stores arrived before the timeout",
               test, store_q.size(), expect_q.size());
    end
    else
    begin
      foreach (expect_q[i])
      begin
        compare_word($sformatf("%s store %0d address", test, i),
                     expect_q[i].address, store_q[i].address);
        compare_word($sformatf("%s store %0d data", test, i),
                     expect_q[i].data, store_q[i].data);
      end
    end
    expect_q.delete();
  endtask

  task automatic test_reset();
    apply_reset();
    repeat (20)
    begin
      @(negedge clock);
      compare_bit("reset fetch_read", 1'b0, fetch_read);
      compare_bit("reset memory_read", 1'b0, memory_read);
      compare_bit("reset memory_write", 1'b0, memory_write);
    end
  endtask

  task automatic test_fetch_sequence();
    word_t base;
    base = 32'h0000_0400;
    program_q.delete();
    start_program(base);
    for (int i = 0; i < 9; i++)
    begin
      compare_bit($sformatf("fetch %0d read", i), 1'b1, fetch_read);
      compare_word($sformatf("fetch %0d address", i), base + 4 * i, fetch_address_out);
      @(negedge clock);
    end
  endtask

  // each op reads the previous result and an older one further back
  task automatic test_dependent_arith();
    word_t x [16];
    x    = '{default: '0};
    x[7] = 32'hffff_fd23; // -733
    x[1] = 32'h0000_05a3;
    x[2] = x[1] + x[7];
    x[3] = x[2] - x[7];
    x[4] = x[3] ^ x[7];
    x[5] = x[4] | x[1];
    x[6] = x[5] & x[7];
    program_q.delete();
    program_q.push_back(i_format(12'hd23, 5'd0, F3_ADD_SUB, 5'd7, OP_IMM));
    program_q.push_back(i_format(12'h5a3, 5'd0, F3_ADD_SUB, 5'd1, OP_IMM));
    program_q.push_back(r_format(7'h00, 5'd7, 5'd1, F3_ADD_SUB, 5'd2)); // x7 from mi
    program_q.push_back(r_format(7'h20, 5'd7, 5'd2, F3_ADD_SUB, 5'd3)); // x7 from mr
    program_q.push_back(r_format(7'h00, 5'd7, 5'd3, F3_XOR, 5'd4));     // x7 from wb
    program_q.push_back(r_format(7'h00, 5'd1, 5'd4, F3_OR, 5'd5));
    program_q.push_back(r_format(7'h00, 5'd7, 5'd5, F3_AND, 5'd6));
    for (int r = 6; r >= 1; r--)
      store_and_expect(reg_idx_t'(r), word_t'(32'h100 + 4 * (6 - r)), x[r]);
    start_program(32'h0000_1000);
    check_stores("arith");
  endtask

  task automatic test_immediates_shifts();
    word_t      x [16];
    word_t      a;
    word_t      b;
    logic [4:0] sh_left;
    logic [4:0] sh_right;
    reg_idx_t   stored [10] = '{0, 3, 4, 5, 6, 8, 9, 10, 11, 0}; // x0 early and late
    x        = '{default: '0};
    a        = $random(seed) | 32'h8000_0000; // negative
    b        = $random(seed) & 32'h7fff_ffff; // positive
    sh_left  = $random(seed);
    sh_right = $random(seed);
    x[3]  = 32'habcd_e000;
    x[4]  = b << sh_left;
    x[5]  = (a >> sh_right) | ~(32'hffff_ffff >> sh_right); // sign bits fill in
    x[6]  = a >> b[4:0];
    x[8]  = 32'd1; // negative below positive when signed
    x[9]  = 32'd0; // but above it unsigned
    x[10] = 32'd0;
    x[11] = 32'd1;
    program_q.delete();
    load_constant(5'd1, a);
    load_constant(5'd2, b);
    program_q.push_back(u_format(20'habcde, 5'd3));
    program_q.push_back(i_format({7'h00, sh_left}, 5'd2, F3_SLL, 5'd4, OP_IMM));
    program_q.push_back(i_format({7'h20, sh_right}, 5'd1, F3_SRL_SRA, 5'd5, OP_IMM));
    program_q.push_back(r_format(7'h00, 5'd2, 5'd1, F3_SRL_SRA, 5'd6));
    program_q.push_back(r_format(7'h00, 5'd2, 5'd1, F3_SLT, 5'd8));
    program_q.push_back(r_format(7'h00, 5'd2, 5'd1, F3_SLTU, 5'd9));
    program_q.push_back(r_format(7'h00, 5'd1, 5'd2, F3_SLT, 5'd10));
    program_q.push_back(r_format(7'h00, 5'd1, 5'd2, F3_SLTU, 5'd11));
    program_q.push_back(r_format(7'h00, 5'd2, 5'd1, F3_ADD_SUB, 5'd0)); // x0 stays zero
    foreach (stored[k])
      store_and_expect(stored[k], word_t'(32'h200 + 4 * k), x[stored[k]]);
    start_program(32'h0000_2000);
    check_stores("imm shift");
  endtask

  task automatic test_loads();
    word_t d0;
    word_t d1;
    d0 = $random(seed);
    d1 = $random(seed);
    data_mem[32'h300] = d0;
    data_mem[32'h304] = d1;
    program_q.delete();
    program_q.push_back(i_format(12'h300, 5'd0, F3_WORD, 5'd1, OP_LOAD));
    program_q.push_back(i_format(12'h304, 5'd0, F3_WORD, 5'd2, OP_LOAD));
    program_q.push_back(i_format(12'd17, 5'd0, F3_ADD_SUB, 5'd3, OP_IMM));
    program_q.push_back(i_format(12'd3, 5'd0, F3_ADD_SUB, 5'd5, OP_IMM));
    program_q.push_back(r_format(7'h00, 5'd2, 5'd1, F3_ADD_SUB, 5'd4));
    store_and_expect(5'd4, 32'h310, d0 + d1);
    store_and_expect(5'd1, 32'h314, d0);
    start_program(32'h0000_3000);
    check_stores("loads");
    if (load_q.size() != 2)
    begin
      other_errors++;
      $display("loads: expected 2 memory reads but saw %0d", load_q.size());
    end
    else
    begin
      compare_word("loads read 0 address", 32'h300, load_q[0]);
      compare_word("loads read 1 address", 32'h304, load_q[1]);
    end
  endtask

  task automatic test_store_latency();
    word_t base;
    word_t store_pc;
    int    fetch_cycle;
    int    write_cycle;
    int    waited;
    base     = 32'h0000_0800;
    store_pc = base + 32'd12;
    program_q.delete();
    program_q.push_back(i_format(12'h02a, 5'd0, F3_ADD_SUB, 5'd1, OP_IMM));
    program_q.push_back(NOP_INSTR);
    program_q.push_back(NOP_INSTR);
    store_and_expect(5'd1, 32'h400, 32'h0000_002a);
    start_program(base);
    waited = 0;
    while (!(fetch_read && fetch_address_out == store_pc) && waited < 50)
    begin
      @(negedge clock);
      waited++;
    end
    fetch_cycle = cycle_count;
    if (!(fetch_read && fetch_address_out == store_pc))
    begin
      other_errors++;
      $display("latency: the store was never fetched");
    end
    else
    begin
      waited = 0;
      while (!memory_write && waited < 50)
      begin
        @(negedge clock);
        waited++;
      end
      write_cycle = cycle_count;
      if (!memory_write)
      begin
        other_errors++;
        $display("latency: memory_write never rose after the store fetch");
      end
      else
      begin
        compare_word("latency cycles", 32'd4, word_t'(write_cycle - fetch_cycle));
      end
    end
    check_stores("latency");
  endtask

  initial
  begin
    clock           = 1'b0;
    reset           = 1'b1;
    start           = 1'b0;
    program_address = '0;
    test_reset();
    test_fetch_sequence();
    test_dependent_arith();
    test_immediates_shifts();
    test_loads();
    test_store_latency();
    $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
             checks, value_errors, other_errors, dut0.assert0.failures);
    if (value_errors == 0 && other_errors == 0 && dut0.assert0.failures == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* verilog/decode_unit.sv */
`timescale 1ns/100ps

module decode_unit
  import rv32_isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  word_t        instruction,
  input  reg_write_t   wb_write,
  input  reg_write_t   ex_fwd,
  input  reg_write_t   mi_fwd,
  input  reg_write_t   mr_fwd,
  input  reg_write_t   wb_fwd,
  output execute_pkt_t ex_pkt
);

  opcode_e      opcode;
  logic [2:0]   funct3;
  logic         alt;       // instruction bit 30, sub and sra
  reg_idx_t     rs1;
  reg_idx_t     rs2;
  reg_idx_t     rd;
  word_t        imm_i;
  word_t        imm_s;
  word_t        imm_u;
  word_t        rs1_data;
  word_t        rs2_data;
  word_t        rs1_value;
  word_t        rs2_value;
  execute_pkt_t next_pkt;

  assign opcode = opcode_e'(instruction[6:0]);
  assign funct3 = instruction[14:12];
  assign alt    = instruction[30];
  assign rs1    = instruction[19:15];
  assign rs2    = instruction[24:20];
  assign rd     = instruction[11:7];

  assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
  assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
  assign imm_u = {instruction[31:12], 12'b0};

  register_file rf0 (
    .clock    (clock),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .write    (wb_write),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // youngest matching producer wins
  function automatic word_t bypass(reg_idx_t idx, word_t rf_value, reg_write_t ex,
                                   reg_write_t mi, reg_write_t mr, reg_write_t wb);
    word_t value;
    value = rf_value;
    if (idx != '0)
    begin
      if (ex.reg_write && ex.rd == idx)
        value = ex.value;
      else if (mi.reg_write && mi.rd == idx)
        value = mi.value;
      else if (mr.reg_write && mr.rd == idx)
        value = mr.value;
      else if (wb.reg_write && wb.rd == idx)
        value = wb.value; // written this cycle, not yet visible
    end
    return value;
  endfunction

  function automatic alu_op_e map_alu(logic [2:0] f3, logic is_reg, logic sel_alt);
    alu_op_e op;
    case (f3)
      F3_ADD_SUB: op = (is_reg && sel_alt) ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = sel_alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      default:    op = ALU_AND;
    endcase
    return op;
  endfunction

  assign rs1_value = bypass(rs1, rs1_data, ex_fwd, mi_fwd, mr_fwd, wb_fwd);
  assign rs2_value = bypass(rs2, rs2_data, ex_fwd, mi_fwd, mr_fwd, wb_fwd);

  always_comb
  begin
    next_pkt            = '0; // no-op unless decoded below
    next_pkt.alu_op     = ALU_ADD;
    next_pkt.operand_a  = rs1_value;
    next_pkt.operand_b  = rs2_value;
    next_pkt.store_data = rs2_value;
    next_pkt.rd         = rd;
    case (opcode)
      OP_REG:
      begin
        next_pkt.alu_op    = map_alu(funct3, 1'b1, alt);
        next_pkt.reg_write = 1'b1;
      end
      OP_IMM:
      begin
        next_pkt.alu_op    = map_alu(funct3, 1'b0, alt);
        next_pkt.operand_b = imm_i; // shamt sits in the low 5 bits
        next_pkt.reg_write = 1'b1;
      end
      OP_LUI:
      begin
        next_pkt.alu_op    = ALU_PASS_B;
        next_pkt.operand_b = imm_u;
        next_pkt.reg_write = 1'b1;
      end
      OP_LOAD:
      begin
        next_pkt.operand_b = imm_i;
        next_pkt.reg_write = (funct3 == F3_WORD);
        next_pkt.mem_read  = (funct3 == F3_WORD);
      end
      OP_STORE:
      begin
        next_pkt.operand_b = imm_s;
        next_pkt.mem_write = (funct3 == F3_WORD);
      end
      default:
      begin
        next_pkt.reg_write = 1'b0; // unknown opcode
      end
    endcase
  end

  // execute pipe register
  always_ff @(posedge clock)
  begin
    if (reset)
      ex_pkt <= '0;
    else
      ex_pkt <= next_pkt;
  end

endmodule

/* verilog/execution_unit.sv */
`timescale 1ns/100ps

module execution_unit
  import rv32_isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  execute_pkt_t ex_pkt,
  output reg_write_t   ex_fwd,
  output memory_pkt_t  mem_pkt
);

  word_t      alu_result;
  logic [4:0] shamt;

  assign shamt = ex_pkt.operand_b[4:0];

  always_comb
  begin
    case (ex_pkt.alu_op)
      ALU_ADD:    alu_result = ex_pkt.operand_a + ex_pkt.operand_b;
      ALU_SUB:    alu_result = ex_pkt.operand_a - ex_pkt.operand_b;
      ALU_AND:    alu_result = ex_pkt.operand_a & ex_pkt.operand_b;
      ALU_OR:     alu_result = ex_pkt.operand_a | ex_pkt.operand_b;
      ALU_XOR:    alu_result = ex_pkt.operand_a ^ ex_pkt.operand_b;
      ALU_SLL:    alu_result = ex_pkt.operand_a << shamt;
      ALU_SRL:    alu_result = ex_pkt.operand_a >> shamt;
      ALU_SRA:    alu_result = word_t'($signed(ex_pkt.operand_a) >>> shamt);
      ALU_SLT:    alu_result = {31'b0, $signed(ex_pkt.operand_a) < $signed(ex_pkt.operand_b)};
      ALU_SLTU:   alu_result = {31'b0, ex_pkt.operand_a < ex_pkt.operand_b};
      ALU_PASS_B: alu_result = ex_pkt.operand_b;
      default:    alu_result = '0;
    endcase
  end

  // a load has only its address here
  assign ex_fwd.reg_write = ex_pkt.reg_write & ~ex_pkt.mem_read;
  assign ex_fwd.rd        = ex_pkt.rd;
  assign ex_fwd.value     = alu_result;

  // memory issue pipe register
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      mem_pkt <= '0;
    end
    else
    begin
      mem_pkt.alu_result <= alu_result;
      mem_pkt.store_data <= ex_pkt.store_data;
      mem_pkt.rd         <= ex_pkt.rd;
      mem_pkt.reg_write  <= ex_pkt.reg_write;
      mem_pkt.mem_read   <= ex_pkt.mem_read;
      mem_pkt.mem_write  <= ex_pkt.mem_write;
    end
  end

endmodule

/* verilog/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit
  import rv32_isa_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  start,
  input  word_t program_address,
  input  word_t fetch_data_in,
  output logic  fetch_read,
  output word_t fetch_address_out,
  output word_t instruction
);

  typedef enum logic {
    FETCH_IDLE,
    FETCH_RUN
  } fetch_state_e;

  fetch_state_e state;
  logic         fetch_pending; // fetch_read one cycle late

  assign fetch_read = (state == FETCH_RUN);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state             <= FETCH_IDLE;
      fetch_address_out <= '0;
    end
    else if (state == FETCH_IDLE)
    begin
      fetch_address_out <= program_address; // first fetch address
      if (start)
        state <= FETCH_RUN;
    end
    else
    begin
      fetch_address_out <= fetch_address_out + 32'd4; // sequential words only
    end
  end

  // fetch receive stage
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      fetch_pending <= 1'b0;
      instruction   <= NOP_INSTR;
    end
    else
    begin
      fetch_pending <= fetch_read;
      instruction   <= fetch_pending ? fetch_data_in : NOP_INSTR; // bubble when idle
    end
  end

endmodule

/* verilog/memory_writeback_unit.sv */
`timescale 1ns/100ps

module memory_writeback_unit
  import rv32_isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  memory_pkt_t mem_pkt,
  input  word_t       memory_data_in,
  output logic        memory_read,
  output logic        memory_write,
  output word_t       memory_address_out,
  output word_t       memory_data_out,
  output reg_write_t  mi_fwd,
  output reg_write_t  mr_fwd,
  output reg_write_t  wb_fwd,
  output reg_write_t  wb_write
);

  reg_write_t receive_reg;  // value holds the alu result
  logic       receive_load; // value comes from memory instead
  reg_write_t writeback_reg;

  // memory issue stage
  assign memory_read        = mem_pkt.mem_read;
  assign memory_write       = mem_pkt.mem_write;
  assign memory_address_out = mem_pkt.alu_result;
  assign memory_data_out    = mem_pkt.store_data;

  assign mi_fwd.reg_write = mem_pkt.reg_write & ~mem_pkt.mem_read; // load data not back yet
  assign mi_fwd.rd        = mem_pkt.rd;
  assign mi_fwd.value     = mem_pkt.alu_result;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      receive_reg  <= '0;
      receive_load <= 1'b0;
    end
    else
    begin
      receive_reg.reg_write <= mem_pkt.reg_write;
      receive_reg.rd        <= mem_pkt.rd;
      receive_reg.value     <= mem_pkt.alu_result;
      receive_load          <= mem_pkt.mem_read;
    end
  end

  // memory receive stage, read data arrives this cycle
  assign mr_fwd.reg_write = receive_reg.reg_write;
  assign mr_fwd.rd        = receive_reg.rd;
  assign mr_fwd.value     = receive_load ? memory_data_in : receive_reg.value;

  always_ff @(posedge clock)
  begin
    if (reset)
      writeback_reg <= '0;
    else
      writeback_reg <= mr_fwd;
  end

  // the writeback register feeds both the register file and the bypass
  assign wb_write = writeback_reg;
  assign wb_fwd   = writeback_reg;

endmodule

/* verilog/pipe_pkg.sv */
package pipe_pkg;

  import rv32_isa_pkg::*;

  // decode to execute
  typedef struct packed {
    alu_op_e  alu_op;
    word_t    operand_a;
    word_t    operand_b;  // immediate already selected
    word_t    store_data;
    reg_idx_t rd;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
  } execute_pkt_t;

  // execute to memory issue
  typedef struct packed {
    word_t    alu_result; // also the memory address
    word_t    store_data;
    reg_idx_t rd;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
  } memory_pkt_t;

  // writeback packet, also the shape of every bypass source
  typedef struct packed {
    logic     reg_write;
    reg_idx_t rd;
    word_t    value;
  } reg_write_t;

endpackage

/* verilog/register_file.sv */
`timescale 1ns/100ps

module register_file
  import rv32_isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  reg_idx_t   rs1,
  input  reg_idx_t   rs2,
  input  reg_write_t write,
  output word_t      rs1_data,
  output word_t      rs2_data
);

  word_t regs [32];

  // asynchronous reads
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (write.reg_write && write.rd != '0)
    begin
      regs[write.rd] <= write.value; // x0 stays zero
    end
  end

endmodule

/* verilog/rv32_isa_pkg.sv */
package rv32_isa_pkg;

  typedef logic [31:0] word_t;    // register value, address or instruction
  typedef logic [4:0]  reg_idx_t; // architectural register number

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    OP_REG   = 7'b0110011,
    OP_IMM   = 7'b0010011,
    OP_LUI   = 7'b0110111,
    OP_LOAD  = 7'b0000011,
    OP_STORE = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B // lui result
  } alu_op_e;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_WORD    = 3'b010; // lw and sw

  localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

endpackage

/* verilog/seven_stage_core.sv */
`timescale 1ns/100ps

module seven_stage_core
  import rv32_isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  start,
  input  word_t program_address,
  input  word_t fetch_data_in,
  input  word_t memory_data_in,
  output logic  fetch_read,
  output word_t fetch_address_out,
  output logic  memory_read,
  output logic  memory_write,
  output word_t memory_address_out,
  output word_t memory_data_out
);

  word_t        instruction; // fetch receive to decode
  execute_pkt_t ex_pkt;
  memory_pkt_t  mem_pkt;
  reg_write_t   wb_write;
  reg_write_t   ex_fwd;
  reg_write_t   mi_fwd;
  reg_write_t   mr_fwd;
  reg_write_t   wb_fwd;

  fetch_unit fetch0 (
    .clock             (clock),
    .reset             (reset),
    .start             (start),
    .program_address   (program_address),
    .fetch_data_in     (fetch_data_in),
    .fetch_read        (fetch_read),
    .fetch_address_out (fetch_address_out),
    .instruction       (instruction)
  );

  decode_unit decode0 (
    .clock       (clock),
    .reset       (reset),
    .instruction (instruction),
    .wb_write    (wb_write),
    .ex_fwd      (ex_fwd),
    .mi_fwd      (mi_fwd),
    .mr_fwd      (mr_fwd),
    .wb_fwd      (wb_fwd),
    .ex_pkt      (ex_pkt)
  );

  execution_unit execute0 (
    .clock   (clock),
    .reset   (reset),
    .ex_pkt  (ex_pkt),
    .ex_fwd  (ex_fwd),
    .mem_pkt (mem_pkt)
  );

  memory_writeback_unit memwb0 (
    .clock              (clock),
    .reset              (reset),
    .mem_pkt            (mem_pkt),
    .memory_data_in     (memory_data_in),
    .memory_read        (memory_read),
    .memory_write       (memory_write),
    .memory_address_out (memory_address_out),
    .memory_data_out    (memory_data_out),
    .mi_fwd             (mi_fwd),
    .mr_fwd             (mr_fwd),
    .wb_fwd             (wb_fwd),
    .wb_write           (wb_write)
  );

endmodule
